// File: verilog/msg_pkg.sv
package msg_pkg;

  // ************************************************************************
  // Word and field widths
  // ************************************************************************
  localparam int msg_width  = 32;
  localparam int addr_width = 8;
  localparam int len_width  = 8;
  localparam int op_width   = 4;

  // Header opcodes
  localparam logic [op_width-1:0] op_write = 4'd1;
  localparam logic [op_width-1:0] op_read  = 4'd2;

  // All-ones word closes the host stream
  localparam logic [msg_width-1:0] end_marker = '1;

  // Default depth of the host FIFOs
  localparam int fifo_depth = 16;

  // Decoder FSM encoding
  localparam logic [1:0] dec_st_hdr    = 2'd0;
  localparam logic [1:0] dec_st_wdata  = 2'd1;
  localparam logic [1:0] dec_st_rissue = 2'd2;

  // ************************************************************************
  // One host word, seen as a header or as plain data
  // ************************************************************************
  typedef struct packed {
    logic [op_width-1:0]   opcode;
    logic [11:0]           rsvd;
    logic [len_width-1:0]  len;
    logic [addr_width-1:0] addr;
  } msg_hdr_t;

  typedef union packed {
    msg_hdr_t             hdr;
    logic [msg_width-1:0] data;
  } msg_word_u;

endpackage

// File: verilog/msg_stream_if.sv
`timescale 1ns/10ps

// Word stream between blocks, transfer on valid and ready both high
interface msg_stream_if;

  logic                          valid;
  logic                          ready;
  logic [msg_pkg::msg_width-1:0] data;
  // Flags the end marker slot, low on all other paths
  logic                          last;

  modport source (
    output valid,
    output data,
    output last,
    input  ready
  );

  modport sink (
    input  valid,
    input  data,
    input  last,
    output ready
  );

endinterface

// File: verilog/mem_op_if.sv
`timescale 1ns/10ps

// One memory operation from the decoder to the executor
interface mem_op_if;

  logic                           valid;
  logic                           ready;
  logic                           is_read;
  // End marker travelling in order with the reads
  logic                           last;
  logic [msg_pkg::addr_width-1:0] addr;
  logic [msg_pkg::msg_width-1:0]  wdata;

  modport issuer (
    output valid, is_read, last, addr, wdata,
    input  ready
  );

  modport executor (
    input  valid, is_read, last, addr, wdata,
    output ready
  );

endinterface

// File: verilog/host_fifo.sv
`timescale 1ns/10ps

// First-word-fall-through FIFO, last travels with each word
module host_fifo #(
  parameter int DEPTH = msg_pkg::fifo_depth
) (
  input  logic         bus_clk,
  input  logic         rst,
  msg_stream_if.sink   wr,
  msg_stream_if.source rd
);

  logic [msg_pkg::msg_width:0]  store [DEPTH];
  logic [$clog2(DEPTH)-1:0]     wr_ptr;
  logic [$clog2(DEPTH)-1:0]     rd_ptr;
  logic [$clog2(DEPTH+1)-1:0]   count;
  logic                         push;
  logic                         pop;

  // Full only when all DEPTH slots hold a word
  assign wr.ready = (count != ($clog2(DEPTH+1))'(DEPTH));
  assign rd.valid = (count != '0);
  assign rd.data  = store[rd_ptr][msg_pkg::msg_width-1:0];
  assign rd.last  = store[rd_ptr][msg_pkg::msg_width];

  assign push = wr.valid && wr.ready;
  assign pop  = rd.valid && rd.ready;

  always_ff @(posedge bus_clk) begin
    if (push) begin
      store[wr_ptr] <= {wr.last, wr.data};
    end
  end

  // ************************************************************************
  // Pointers and occupancy
  // ************************************************************************
  always_ff @(posedge bus_clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: verilog/msg_decode.sv
`timescale 1ns/10ps

module msg_decode (
  input  logic         bus_clk,
  input  logic         rst,
  msg_stream_if.sink   in,
  msg_stream_if.source loop,
  mem_op_if.issuer     op,
  output logic         error
);

  logic [1:0]                     state;
  logic [msg_pkg::len_width-1:0]  remaining;
  logic [msg_pkg::addr_width-1:0] addr_q;
  logic                           ended;
  msg_pkg::msg_word_u             word;
  logic                           is_end;
  logic                           take;
  logic                           op_fire;

  assign word    = in.data;
  assign is_end  = (word.data == msg_pkg::end_marker);
  assign take    = in.valid && in.ready;
  assign op_fire = op.valid && op.ready;

  // Every consumed word is copied to the host loopback
  assign loop.valid = take;
  assign loop.data  = in.data;
  assign loop.last  = 1'b0;

  // ************************************************************************
  // Handshake steering per state
  // ************************************************************************
  always_comb begin
    in.ready   = 1'b0;
    op.valid   = 1'b0;
    op.is_read = 1'b0;
    op.last    = 1'b0;
    op.addr    = addr_q;
    op.wdata   = word.data;
    if (!ended) begin
      case (state)
        msg_pkg::dec_st_hdr: begin
          if (is_end) begin
            // End marker goes out as a last operation
            op.valid = in.valid && loop.ready;
            op.last  = 1'b1;
            in.ready = loop.ready && op.ready;
          end else begin
            in.ready = loop.ready;
          end
        end
        msg_pkg::dec_st_wdata: begin
          op.valid = in.valid && loop.ready;
          in.ready = loop.ready && op.ready;
        end
        default: begin
          op.valid   = 1'b1;
          op.is_read = 1'b1;
        end
      endcase
    end
  end

  always_ff @(posedge bus_clk) begin
    if (rst) begin
      state     <= msg_pkg::dec_st_hdr;
      remaining <= '0;
      addr_q    <= '0;
      ended     <= 1'b0;
      error     <= 1'b0;
    end else if (state == msg_pkg::dec_st_hdr) begin
      if (take) begin
        if (is_end) begin
          ended <= 1'b1;
        end else if (word.hdr.opcode == msg_pkg::op_write ||
                     word.hdr.opcode == msg_pkg::op_read) begin
          remaining <= word.hdr.len;
          addr_q    <= word.hdr.addr;
          // Zero length issues nothing
          if (word.hdr.len != '0) begin
            state <= (word.hdr.opcode == msg_pkg::op_write) ?
                     msg_pkg::dec_st_wdata : msg_pkg::dec_st_rissue;
          end
        end else begin
          error <= 1'b1;
        end
      end
    end else if (op_fire) begin
      // One address per write data word or read issue
      addr_q    <= addr_q + 1'b1;
      remaining <= remaining - 1'b1;
      if (remaining == 1) begin
        state <= msg_pkg::dec_st_hdr;
      end
    end
  end

endmodule

// File: verilog/mem_execute.sv
`timescale 1ns/10ps

// On-chip memory standing in for the DRAM behind the host engine
module mem_execute (
  input  logic         bus_clk,
  input  logic         rst,
  mem_op_if.executor   op,
  msg_stream_if.source rdata
);

  logic [msg_pkg::msg_width-1:0] mem [1 << msg_pkg::addr_width];
  logic [msg_pkg::msg_width-1:0] res_data;
  logic                          res_valid;
  logic                          res_last;
  logic                          needs_slot;
  logic                          slot_free;
  logic                          op_fire;

  // Reads and the end marker need the result register, writes never stall
  assign needs_slot = op.is_read || op.last;
  assign slot_free  = !res_valid || rdata.ready;
  assign op.ready   = !needs_slot || slot_free;
  assign op_fire    = op.valid && op.ready;

  assign rdata.valid = res_valid;
  assign rdata.data  = res_data;
  assign rdata.last  = res_last;

  // ************************************************************************
  // Memory array with registered read
  // ************************************************************************
  always_ff @(posedge bus_clk) begin
    if (op_fire && !needs_slot) begin
      mem[op.addr] <= op.wdata;
    end
    if (op_fire && needs_slot) begin
      res_data <= op.last ? msg_pkg::end_marker : mem[op.addr];
    end
  end

  // Result register, held until taken
  always_ff @(posedge bus_clk) begin
    if (rst) begin
      res_valid <= 1'b0;
      res_last  <= 1'b0;
    end else if (op_fire && needs_slot) begin
      res_valid <= 1'b1;
      res_last  <= op.last;
    end else if (rdata.ready) begin
      res_valid <= 1'b0;
      res_last  <= 1'b0;
    end
  end

endmodule

// File: verilog/reply_result.sv
`timescale 1ns/10ps

// Queues read words for the host and tracks end of stream
module reply_result (
  input  logic         bus_clk,
  input  logic         rst,
  msg_stream_if.sink   rdata,
  msg_stream_if.source out,
  output logic         eof
);

  msg_stream_if fifo_in ();

  logic end_seen;

  // The last marker is absorbed here, only real read data is queued
  assign fifo_in.valid = rdata.valid && !rdata.last;
  assign fifo_in.data  = rdata.data;
  assign fifo_in.last  = 1'b0;
  assign rdata.ready   = rdata.last ? 1'b1 : fifo_in.ready;

  host_fifo #(
    .DEPTH (msg_pkg::fifo_depth)
  ) u_out_fifo (
    .bus_clk (bus_clk),
    .rst     (rst),
    .wr      (fifo_in),
    .rd      (out)
  );

  // Sticky once the end marker has been taken
  always_ff @(posedge bus_clk) begin
    if (rst) begin
      end_seen <= 1'b0;
    end else if (rdata.valid && rdata.last) begin
      end_seen <= 1'b1;
    end
  end

  // EOF waits for the output queue to drain
  assign eof = end_seen && !out.valid;

endmodule

// File: verilog/msg_engine_top.sv
`timescale 1ns/10ps

module msg_engine_top (
  input  logic                          bus_clk,
  input  logic                          rst,
  input  logic                          in_valid,
  input  logic [msg_pkg::msg_width-1:0] in_data,
  output logic                          in_ready,
  output logic                          out_valid,
  output logic [msg_pkg::msg_width-1:0] out_data,
  input  logic                          out_ready,
  output logic                          loop_valid,
  output logic [msg_pkg::msg_width-1:0] loop_data,
  input  logic                          loop_ready,
  output logic                          out_eof,
  output logic                          error
);

  msg_stream_if host_in ();
  msg_stream_if dec_in ();
  msg_stream_if loop_wr ();
  msg_stream_if loop_rd ();
  msg_stream_if rdata ();
  msg_stream_if out_s ();
  mem_op_if     mem_op ();

  // ************************************************************************
  // Host side stream mapping
  // ************************************************************************
  assign host_in.valid = in_valid;
  assign host_in.data  = in_data;
  assign host_in.last  = 1'b0;
  assign in_ready      = host_in.ready;

  assign loop_valid    = loop_rd.valid;
  assign loop_data     = loop_rd.data;
  assign loop_rd.ready = loop_ready;

  assign out_valid     = out_s.valid;
  assign out_data      = out_s.data;
  assign out_s.ready   = out_ready;

  // Input and loopback queues
  host_fifo #(.DEPTH(msg_pkg::fifo_depth)) u_in_fifo (
    .bus_clk (bus_clk), .rst (rst), .wr (host_in), .rd (dec_in)
  );

  host_fifo #(.DEPTH(msg_pkg::fifo_depth)) u_loop_fifo (
    .bus_clk (bus_clk), .rst (rst), .wr (loop_wr), .rd (loop_rd)
  );

  msg_decode u_decode (
    .bus_clk (bus_clk), .rst (rst), .in (dec_in), .loop (loop_wr),
    .op (mem_op), .error (error)
  );

  mem_execute u_execute (
    .bus_clk (bus_clk), .rst (rst), .op (mem_op), .rdata (rdata)
  );

  reply_result u_result (
    .bus_clk (bus_clk), .rst (rst), .rdata (rdata), .out (out_s), .eof (out_eof)
  );

endmodule

// File: sim/tb_msg_engine.sv
`timescale 1ns/10ps

module tb_msg_engine;

  logic        bus_clk;
  logic        rst;
  logic        in_valid;
  logic [31:0] in_data;
  logic        in_ready;
  logic        out_valid;
  logic [31:0] out_data;
  logic        out_ready;
  logic        loop_valid;
  logic [31:0] loop_data;
  logic        loop_ready;
  logic        out_eof;
  logic        error;

  // Reference model and stimulus bookkeeping
  logic [31:0] rng;
  logic [31:0] ref_mem [256];
  logic [31:0] in_words [$];
  logic [31:0] exp_out [$];
  logic [31:0] exp_loop [$];
  int          bad_idx;
  int          stall_start;
  int          stall_end;
  int          end_idx;
  logic        stim_ready;
  logic        out_hold;
  logic        in_stall_seen;
  logic        bad_sent;
  logic        end_sent;
  logic        error_seen;
  logic        eof_seen;

  msg_engine_top i_dut (
    .bus_clk    (bus_clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_data    (in_data),
    .in_ready   (in_ready),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_ready  (out_ready),
    .loop_valid (loop_valid),
    .loop_data  (loop_data),
    .loop_ready (loop_ready),
    .out_eof    (out_eof),
    .error      (error)
  );

  initial begin
    bus_clk = 1'b0;
    forever #2 bus_clk = ~bus_clk;
  end

  task automatic stop_on_error();
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp);
    stop_on_error();
  endtask

  task automatic report_failure(input string what);
    $display("Failure at %0t: %s", $time, what);
    stop_on_error();
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // ************************************************************************
  // Message building with the reference memory model
  // ************************************************************************
  task automatic queue_word(input logic [31:0] w);
    in_words.push_back(w);
    exp_loop.push_back(w);
  endtask

  task automatic add_write(input logic [7:0] addr, input logic [7:0] len);
    logic [31:0] w;
    queue_word({msg_pkg::op_write, 12'h000, len, addr});
    for (int i = 0; i < int'(len); i++) begin
      w = next_rand();
      ref_mem[addr + 8'(i)] = w;
      queue_word(w);
    end
  endtask

  task automatic add_read(input logic [7:0] addr, input logic [7:0] len);
    queue_word({msg_pkg::op_read, 12'h000, len, addr});
    for (int i = 0; i < int'(len); i++) begin
      exp_out.push_back(ref_mem[addr + 8'(i)]);
    end
  endtask

  initial begin : main_seq
    logic [31:0] r;
    logic [7:0]  a;
    logic [7:0]  n;
    int          low_cycles;
    rst = 1'b1;
    in_valid = 1'b0;
    in_data = '0;
    out_ready = 1'b0;
    loop_ready = 1'b0;
    rng = 32'h31d4;
    {stim_ready, out_hold, in_stall_seen, bad_sent, end_sent} = '0;
    {error_seen, eof_seen} = '0;
    for (int k = 0; k < 6; k++) begin
      r = next_rand();
      a = r[7:0];
      n = 8'(r[12:8]) + 8'd1;
      add_write(a, n);
      add_read(a, n);
    end
    // Zero length headers issue nothing
    add_read(a, 8'd0);
    add_write(a, 8'd0);
    bad_idx = in_words.size();
    queue_word({4'hc, 12'h000, 8'd5, 8'h09});
    add_write(8'hf8, 8'd12);
    add_read(8'hf8, 8'd12);
    // Long read against a held output and more input to fill the input FIFO
    stall_start = in_words.size();
    add_write(8'h40, 8'd40);
    add_read(8'h40, 8'd40);
    add_write(8'h80, 8'd24);
    stall_end = in_words.size();
    add_read(8'h80, 8'd24);
    end_idx = in_words.size();
    queue_word(msg_pkg::end_marker);
    // Ignored after the end marker
    in_words.push_back({msg_pkg::op_read, 12'h000, 8'd4, 8'h40});
    in_words.push_back({msg_pkg::op_write, 12'h000, 8'd1, 8'h40});
    stim_ready = 1'b1;

    repeat (3) @(negedge bus_clk);
    rst = 1'b0;
    @(negedge bus_clk);
    assert (!out_valid) else report_mismatch("out_valid", {31'b0, out_valid}, 32'h0);
    assert (!loop_valid) else report_mismatch("loop_valid", {31'b0, loop_valid}, 32'h0);
    assert (!out_eof) else report_mismatch("out_eof", {31'b0, out_eof}, 32'h0);
    assert (!error) else report_mismatch("error", {31'b0, error}, 32'h0);
    assert (in_ready) else report_mismatch("in_ready", {31'b0, in_ready}, 32'h1);

    for (int i = 0; i < in_words.size(); i++) begin
      if (i == bad_idx) bad_sent = 1'b1;
      if (i == stall_start) out_hold = 1'b1;
      if (i == end_idx) end_sent = 1'b1;
      if (i == stall_end) begin
        assert (in_stall_seen) else report_failure("in_ready never fell under output stall");
        out_hold = 1'b0;
      end
      r = next_rand();
      if (r[2:0] == 3'd0) begin
        in_valid = 1'b0;
        @(negedge bus_clk);
      end
      in_valid = 1'b1;
      in_data  = in_words[i];
      // in_ready comes from registered occupancy and is stable here
      low_cycles = 0;
      while (!in_ready) begin
        // Only a block lasting past the longest read burst is the output stall
        if (out_hold) begin
          low_cycles = low_cycles + 1;
          if (low_cycles == 64) begin
            in_stall_seen = 1'b1;
            out_hold      = 1'b0;
          end
        end
        @(negedge bus_clk);
      end
      @(negedge bus_clk);
    end
    in_valid = 1'b0;

    while (!(out_eof && exp_out.size() == 0 && exp_loop.size() == 0)) begin
      @(negedge bus_clk);
    end
    // Quiet period for the monitors to catch any stray word
    repeat (16) @(negedge bus_clk);
    assert (error_seen) else report_failure("unknown opcode did not raise error");
    $display("NO ERRORS");
    $finish;
  end

  // ************************************************************************
  // Output side with out_eof and error monitoring
  // ************************************************************************
  initial begin : out_side
    logic [31:0] r;
    logic [31:0] exp;
    forever begin
      @(negedge bus_clk);
      if (!rst) begin
        r = next_rand();
        out_ready = !out_hold && (r[1:0] != 2'b00);
        assert (!out_valid || exp_out.size() != 0)
          else report_failure("output word appeared with none outstanding");
        assert (!out_eof || (end_sent && exp_out.size() == 0))
          else report_failure("out_eof high while read words are outstanding");
        assert (!eof_seen || out_eof) else report_failure("out_eof fell after rising");
        assert (!error || bad_sent) else report_failure("error rose without a bad opcode");
        assert (!error_seen || error) else report_failure("error fell after rising");
        eof_seen   = eof_seen || out_eof;
        error_seen = error_seen || error;
        if (out_valid && out_ready) begin
          exp = exp_out.pop_front();
          assert (out_data == exp) else report_mismatch("out_data", out_data, exp);
        end
      end
    end
  end

  initial begin : loop_side
    logic [31:0] r;
    logic [31:0] exp;
    forever begin
      @(negedge bus_clk);
      if (!rst) begin
        r = next_rand();
        loop_ready = (r[3:2] != 2'b00);
        assert (!loop_valid || exp_loop.size() != 0)
          else report_failure("loopback word appeared beyond the words consumed");
        if (loop_valid && loop_ready) begin
          exp = exp_loop.pop_front();
          assert (loop_data == exp) else report_mismatch("loop_data", loop_data, exp);
        end
      end
    end
  end

  // Bound of 24 cycles per host word plus margin
  initial begin : watchdog
    wait (stim_ready);
    repeat (in_words.size() * 24 + 500) @(posedge bus_clk);
    report_failure("watchdog expired before the stream completed");
  end

endmodule

// File: verilog.f
verilog/msg_pkg.sv
verilog/msg_stream_if.sv
verilog/mem_op_if.sv
verilog/host_fifo.sv
verilog/msg_decode.sv
verilog/mem_execute.sv
verilog/reply_result.sv
verilog/msg_engine_top.sv
sim/tb_msg_engine.sv

// File: run.sh
#!/bin/sh
# Build the message engine testbench with Verilator, run it, grep for the pass line
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -f verilog.f --top-module tb_msg_engine \
    -o sim_msg_engine &&
  ./obj_dir/sim_msg_engine 2>&1 | tee /dev/stderr | grep -q "^NO ERRORS$" &&
  echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }
